// File: rtl/vision_pkg.sv
//--------------------------------------------------------------------------
// vision package
// geometry, colour coefficients and datapath widths shared by the video
// front end and its testbench
//--------------------------------------------------------------------------

package vision_pkg;

   // video byte and pixel word
   localparam int BYTE_W = 8;              // decoder upper data lane
   localparam int PIX_W  = 16;             // rgb565

   //------------------------------------------------------------------------
   // frame store geometry
   //------------------------------------------------------------------------
   localparam int ADR_W = 15;              // word address within one bank

   // 180 x 120 kept pixels per bank
   localparam logic [ADR_W-1:0] FB_WORDS = ADR_W'(21600);

   localparam int H_DECIM = 4;             // keep every fourth pixel
   localparam int V_DECIM = 2;             // keep every second line

   //------------------------------------------------------------------------
   // colour conversion, coefficients in 2.8 fixed point
   //------------------------------------------------------------------------
   localparam int COEF_W = 10;

   localparam logic [COEF_W-1:0] COEF_Y    = 10'b01_0010_1010;  // 1.164
   localparam logic [COEF_W-1:0] COEF_CR_R = 10'b01_1001_1000;  // 1.596
   localparam logic [COEF_W-1:0] COEF_CR_G = 10'b00_1101_0000;  // 0.813
   localparam logic [COEF_W-1:0] COEF_CB_G = 10'b00_0110_0100;  // 0.392
   localparam logic [COEF_W-1:0] COEF_CB_B = 10'b10_0000_0100;  // 2.017

   // products and channel sums
   localparam int ACC_W = 21;

   // offsets apply to the byte scaled by 4
   localparam logic signed [ACC_W-1:0] Y_OFFSET = 21'sd64;
   localparam logic signed [ACC_W-1:0] C_OFFSET = 21'sd512;

endpackage

// File: rtl/ycbcr_capture.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// ycbcr capture
// odd field qualification and Cb/Y/Cr/Y byte sequencing, one pixel strobe
// per luma sample
//--------------------------------------------------------------------------

module ycbcr_capture
   import vision_pkg::*;
(
   input  logic              clk_llc,
   input  logic              resetx,
   input  logic              vref,
   input  logic              href,
   input  logic              odd,
   input  logic [BYTE_W-1:0] vpo,
   output logic              pix_valid,
   output logic [BYTE_W-1:0] pix_y,
   output logic [BYTE_W-1:0] pix_cb,
   output logic [BYTE_W-1:0] pix_cr,
   output logic              line_start,
   output logic              field_end
);

   localparam logic [1:0] PH_CB0 = 2'd0;
   localparam logic [1:0] PH_Y0  = 2'd1;
   localparam logic [1:0] PH_CR0 = 2'd2;
   localparam logic [1:0] PH_Y1  = 2'd3;

   logic              field_q;     // odd field window
   logic              active;
   logic              active_d;
   logic              field_d;
   logic [1:0]        phase;
   logic [BYTE_W-1:0] cb_hold;
   logic [BYTE_W-1:0] y0_hold;

   assign field_q    = odd & vref;
   assign active     = field_q & href;
   assign line_start = active & ~active_d;   // first active cycle of a line

   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         phase     <= PH_CB0;
         active_d  <= 1'b0;
         field_d   <= 1'b0;
         field_end <= 1'b0;
         pix_valid <= 1'b0;
      end
      else
      begin
         phase     <= active ? phase + 2'd1 : PH_CB0;
         active_d  <= active;
         field_d   <= field_q;
         field_end <= field_d & ~field_q;   // one cycle after the fall
         pix_valid <= active & ((phase == PH_CR0) | (phase == PH_Y1));
      end
   end

   // byte latches, chroma shared by both luma samples
   always_ff @(posedge clk_llc)
   begin
      if (active && phase == PH_CB0)
         cb_hold <= vpo;
      if (active && phase == PH_Y0)
         y0_hold <= vpo;
      if (active && phase == PH_CR0)
      begin
         pix_y  <= y0_hold;
         pix_cb <= cb_hold;
         pix_cr <= vpo;
      end
      if (active && phase == PH_Y1)
         pix_y <= vpo;          // second pixel of the pair
   end

   // one Cb/Cr pair never yields more than two pixel strobes in a row
   a_two_per_pair : assert property (@(posedge clk_llc) disable iff (!resetx)
      pix_valid && $past(pix_valid) |-> !$past(pix_valid, 2));

endmodule

// File: rtl/ycbcr_to_rgb565.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// ycbcr to rgb565
// two-stage fixed-point colour conversion with clamping to rgb565
//--------------------------------------------------------------------------

module ycbcr_to_rgb565
   import vision_pkg::*;
(
   input  logic              clk_llc,
   input  logic              resetx,
   input  logic              pix_valid,
   input  logic [BYTE_W-1:0] pix_y,
   input  logic [BYTE_W-1:0] pix_cb,
   input  logic [BYTE_W-1:0] pix_cr,
   output logic              rgb_valid,
   output logic [PIX_W-1:0]  rgb
);

   // zero-extend a 10 bit value into the signed accumulator width
   function automatic logic signed [ACC_W-1:0] widen(input logic [COEF_W-1:0] v);
      widen = $signed({{(ACC_W-COEF_W){1'b0}}, v});
   endfunction

   // saturate each channel, then take the top bits below the guard bits
   function automatic logic [PIX_W-1:0] pack565(input logic signed [ACC_W-1:0] r,
                                               input logic signed [ACC_W-1:0] g,
                                               input logic signed [ACC_W-1:0] b);
      logic [4:0] r5;
      logic [5:0] g6;
      logic [4:0] b5;
      r5 = r[ACC_W-1] ? 5'h00 : (|r[19:18]) ? 5'h1f : r[17:13];
      g6 = g[ACC_W-1] ? 6'h00 : (|g[19:18]) ? 6'h3f : g[17:12];
      b5 = b[ACC_W-1] ? 5'h00 : (|b[19:18]) ? 5'h1f : b[17:13];
      pack565 = {r5, g6, b5};
   endfunction

   logic signed [ACC_W-1:0] y_term;
   logic signed [ACC_W-1:0] cb_term;
   logic signed [ACC_W-1:0] cr_term;

   // stage 1 products
   logic signed [ACC_W-1:0] p_y;
   logic signed [ACC_W-1:0] p_cr_r;
   logic signed [ACC_W-1:0] p_cr_g;
   logic signed [ACC_W-1:0] p_cb_g;
   logic signed [ACC_W-1:0] p_cb_b;

   // stage 2 channel sums
   logic signed [ACC_W-1:0] s_r;
   logic signed [ACC_W-1:0] s_g;
   logic signed [ACC_W-1:0] s_b;

   logic [1:0] valid_pipe;

   // bytes scaled by 4 before the offset
   assign y_term  = widen({pix_y, 2'b00}) - Y_OFFSET;
   assign cb_term = widen({pix_cb, 2'b00}) - C_OFFSET;
   assign cr_term = widen({pix_cr, 2'b00}) - C_OFFSET;

   always_ff @(posedge clk_llc)
   begin
      p_y    <= widen(COEF_Y) * y_term;
      p_cr_r <= widen(COEF_CR_R) * cr_term;
      p_cr_g <= widen(COEF_CR_G) * cr_term;
      p_cb_g <= widen(COEF_CB_G) * cb_term;
      p_cb_b <= widen(COEF_CB_B) * cb_term;

      s_r <= p_y + p_cr_r;
      s_g <= p_y - p_cr_g - p_cb_g;
      s_b <= p_y + p_cb_b;
   end

   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
         valid_pipe <= 2'b00;
      else
         valid_pipe <= {valid_pipe[0], pix_valid};
   end

   assign rgb_valid = valid_pipe[1];
   assign rgb       = pack565(s_r, s_g, s_b);   // clamp on the stage 2 output

endmodule

// File: rtl/frame_writer.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// frame writer
// decimation, write address generation, bank alternation and field-end
// interrupts
//--------------------------------------------------------------------------

module frame_writer
   import vision_pkg::*;
(
   input  logic             clk_llc,
   input  logic             resetx,
   input  logic             rgb_valid,
   input  logic [PIX_W-1:0] rgb,
   input  logic             line_start,
   input  logic             field_end,
   output logic             wr_en,
   output logic             wr_bank,
   output logic [ADR_W-1:0] wr_adr,
   output logic [PIX_W-1:0] wr_data,
   output logic             irq0,
   output logic             irq1
);

   localparam int HC_W = $clog2(H_DECIM);
   localparam int VC_W = $clog2(V_DECIM);
   localparam logic [HC_W-1:0] H_LAST = HC_W'(H_DECIM - 1);
   localparam logic [VC_W-1:0] V_LAST = VC_W'(V_DECIM - 1);

   logic [HC_W-1:0]  h_cnt;       // pixel within line, modulo H_DECIM
   logic [VC_W-1:0]  v_cnt;       // line within field, modulo V_DECIM
   logic             line_seen;   // first line of the field has started
   logic [ADR_W-1:0] adr_cnt;     // next free word
   logic [1:0]       fe_pipe;
   logic             fe_now;
   logic             keep;
   logic             wr_ok;

   // field end waits until the last pixels have left the converter
   assign fe_now = fe_pipe[1];
   assign keep   = rgb_valid && (h_cnt == '0) && (v_cnt == '0);
   assign wr_ok  = keep && (adr_cnt < FB_WORDS);

   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         fe_pipe   <= 2'b00;
         h_cnt     <= '0;
         v_cnt     <= '0;
         line_seen <= 1'b0;
         adr_cnt   <= '0;
         wr_en     <= 1'b0;
         wr_bank   <= 1'b0;
         irq0      <= 1'b0;
         irq1      <= 1'b0;
      end
      else
      begin
         fe_pipe <= {fe_pipe[0], field_end};
         wr_en   <= wr_ok;
         irq0    <= fe_now & wr_bank;    // bank 1 just completed
         irq1    <= fe_now & ~wr_bank;
         if (fe_now)
         begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            line_seen <= 1'b0;
            adr_cnt   <= '0;
            wr_bank   <= ~wr_bank;
         end
         else
         begin
            // a pixel landing with line_start still belongs to the old line
            if (line_start)
            begin
               h_cnt     <= '0;
               line_seen <= 1'b1;
               if (line_seen)
                  v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
            end
            else if (rgb_valid)
               h_cnt <= (h_cnt == H_LAST) ? '0 : h_cnt + 1'b1;
            if (wr_ok)
               adr_cnt <= adr_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_llc)
   begin
      if (wr_ok)
      begin
         wr_adr  <= adr_cnt;
         wr_data <= rgb;
      end
   end

   a_adr_in_bank : assert property (@(posedge clk_llc) disable iff (!resetx)
      wr_en |-> wr_adr < FB_WORDS);

   a_one_irq : assert property (@(posedge clk_llc) disable iff (!resetx)
      !(irq0 && irq1));

endmodule

// File: rtl/frame_buffer.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// frame buffer
// two word banks, one capture write port and a registered host read port
// on the bank not being written
//--------------------------------------------------------------------------

module frame_buffer
   import vision_pkg::*;
(
   input  logic             clk_llc,
   input  logic             resetx,
   input  logic             wr_en,
   input  logic             wr_bank,
   input  logic [ADR_W-1:0] wr_adr,
   input  logic [PIX_W-1:0] wr_data,
   input  logic             host_rd,
   input  logic [ADR_W-1:0] host_adr,
   output logic [PIX_W-1:0] host_data,
   output logic             host_valid
);

   logic [PIX_W-1:0] mem0 [0:FB_WORDS-1];
   logic [PIX_W-1:0] mem1 [0:FB_WORDS-1];

   always_ff @(posedge clk_llc)
   begin
      if (wr_en && !wr_bank)
         mem0[wr_adr] <= wr_data;
      if (wr_en && wr_bank)
         mem1[wr_adr] <= wr_data;
   end

   // host sees the completed bank, one cycle read latency
   always_ff @(posedge clk_llc or negedge resetx)
   begin
      if (!resetx)
      begin
         host_valid <= 1'b0;
         host_data  <= '0;
      end
      else
      begin
         host_valid <= host_rd;
         if (host_rd)
            host_data <= (host_adr >= FB_WORDS) ? '0 :
                         wr_bank ? mem0[host_adr] : mem1[host_adr];
      end
   end

endmodule

// File: rtl/video_front_end.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// video front end
// ycbcr capture, rgb565 conversion and double-buffered frame store
//--------------------------------------------------------------------------

module video_front_end
   import vision_pkg::*;
(
   input  logic              clk_llc,
   input  logic              resetx,
   input  logic              vref,
   input  logic              href,
   input  logic              odd,
   input  logic [BYTE_W-1:0] vpo,
   input  logic              host_rd,
   input  logic [ADR_W-1:0]  host_adr,
   output logic [PIX_W-1:0]  host_data,
   output logic              host_valid,
   output logic              irq0,
   output logic              irq1
);

   // capture to converter
   logic              pix_valid;
   logic [BYTE_W-1:0] pix_y;
   logic [BYTE_W-1:0] pix_cb;
   logic [BYTE_W-1:0] pix_cr;
   logic              line_start;
   logic              field_end;

   // converter to writer
   logic              rgb_valid;
   logic [PIX_W-1:0]  rgb;

   // writer to frame store
   logic              wr_en;
   logic              wr_bank;
   logic [ADR_W-1:0]  wr_adr;
   logic [PIX_W-1:0]  wr_data;

   ycbcr_capture i_capture (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .vref       (vref),
      .href       (href),
      .odd        (odd),
      .vpo        (vpo),
      .pix_valid  (pix_valid),
      .pix_y      (pix_y),
      .pix_cb     (pix_cb),
      .pix_cr     (pix_cr),
      .line_start (line_start),
      .field_end  (field_end)
   );

   ycbcr_to_rgb565 i_convert (
      .clk_llc   (clk_llc),
      .resetx    (resetx),
      .pix_valid (pix_valid),
      .pix_y     (pix_y),
      .pix_cb    (pix_cb),
      .pix_cr    (pix_cr),
      .rgb_valid (rgb_valid),
      .rgb       (rgb)
   );

   frame_writer i_writer (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .rgb_valid  (rgb_valid),
      .rgb        (rgb),
      .line_start (line_start),
      .field_end  (field_end),
      .wr_en      (wr_en),
      .wr_bank    (wr_bank),
      .wr_adr     (wr_adr),
      .wr_data    (wr_data),
      .irq0       (irq0),
      .irq1       (irq1)
   );

   frame_buffer i_fbuf (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .wr_en      (wr_en),
      .wr_bank    (wr_bank),
      .wr_adr     (wr_adr),
      .wr_data    (wr_data),
      .host_rd    (host_rd),
      .host_adr   (host_adr),
      .host_data  (host_data),
      .host_valid (host_valid)
   );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// testbench clock source, 40 ns period
//--------------------------------------------------------------------------

module tb_clock_gen
(
   output logic clk_llc
);

   initial
   begin
      clk_llc = 1'b0;
      forever #20 clk_llc = ~clk_llc;   // 25 MHz line-locked clock
   end

endmodule

// File: test/tb_video_front_end.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// video front end testbench
// replays the field trace, reads back each completed bank and checks the
// colour, decimation count, interrupts and host read timing
//--------------------------------------------------------------------------

module tb_video_front_end
   import vision_pkg::*;
;

   localparam int REC_W    = 7;                  // words per trace record
   localparam int TRACE_D  = 1 + REC_W * 16;
   localparam int IRQ_WAIT = 16;                 // cycles allowed for the irq
   localparam int MIN_READ = 12;

   logic              clk_llc;
   logic              resetx;
   logic              vref;
   logic              href;
   logic              odd;
   logic [BYTE_W-1:0] vpo;
   logic              host_rd;
   logic [ADR_W-1:0]  host_adr;
   logic [PIX_W-1:0]  host_data;
   logic              host_valid;
   logic              irq0;
   logic              irq1;

   logic [15:0]       trace_mem [0:TRACE_D-1];
   logic [PIX_W-1:0]  model [0:1][0:FB_WORDS-1];   // expected bank contents
   bit                known [0:1][0:FB_WORDS-1];
   logic [15:0]       lfsr_state;
   int                limit_cycles = 0;

   tb_clock_gen i_clk (.clk_llc(clk_llc));

   video_front_end i_dut (
      .clk_llc    (clk_llc),
      .resetx     (resetx),
      .vref       (vref),
      .href       (href),
      .odd        (odd),
      .vpo        (vpo),
      .host_rd    (host_rd),
      .host_adr   (host_adr),
      .host_data  (host_data),
      .host_valid (host_valid),
      .irq0       (irq0),
      .irq1       (irq1)
   );

   //------------------------------------------------------------------------
   // compare tasks
   //------------------------------------------------------------------------
   task automatic check_pixel(input string name, input logic [PIX_W-1:0] got,
                              input logic [PIX_W-1:0] exp);
      if (got !== exp)
      begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "pixel mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "flag mismatch");
      end
   endtask

   // 16 bit fibonacci lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic random_bits(input int n, output int val);
      int i;
      val = 0;
      for (i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         val = (val << 1) | int'(lfsr_state[0]);   // one step per bit
      end
   endtask

   // words written by a field of the given size
   function automatic int kept_words(input int lines, input int pairs);
      int n;
      n = ((lines + V_DECIM - 1) / V_DECIM) * ((2 * pairs + H_DECIM - 1) / H_DECIM);
      kept_words = (n > int'(FB_WORDS)) ? int'(FB_WORDS) : n;
   endfunction

   //------------------------------------------------------------------------
   // field stimulus, Cb Y Cr Y per pair
   //------------------------------------------------------------------------
   task automatic drive_field(input logic odd_flag, input int lines, input int pairs,
                              input logic [BYTE_W-1:0] cb, input logic [BYTE_W-1:0] y,
                              input logic [BYTE_W-1:0] cr);
      int ln;
      int k;
      int blank;
      @(posedge clk_llc);
      odd  <= odd_flag;
      vref <= 1'b0;
      href <= 1'b0;
      repeat (4) @(posedge clk_llc);
      vref <= 1'b1;
      repeat (2) @(posedge clk_llc);
      for (ln = 0; ln < lines; ln++)
      begin
         for (k = 0; k < 4 * pairs; k++)
         begin
            @(posedge clk_llc);
            href <= 1'b1;
            if (k % 4 == 0)
               vpo <= cb;
            else if (k % 4 == 2)
               vpo <= cr;
            else
               vpo <= y;
         end
         random_bits(3, blank);
         @(posedge clk_llc);
         href <= 1'b0;
         vpo  <= '0;
         repeat (blank + 1) @(posedge clk_llc);   // href low for 2 to 9 cycles
      end
      vref <= 1'b0;
   endtask

   task automatic wait_irq(input logic bank);
      int n;
      n = 0;
      @(negedge clk_llc);
      while (!(irq0 || irq1) && n < IRQ_WAIT)
      begin
         @(negedge clk_llc);
         n++;
      end
      if (!(irq0 || irq1))
      begin
         $display("no interrupt within %0d cycles after an odd field", IRQ_WAIT);
         $display("STATUS: FAIL");
         $fatal(1, "missing interrupt");
      end
      check_flag("irq0", irq0, bank);
      check_flag("irq1", irq1, ~bank);
      @(negedge clk_llc);
      check_flag("irq0", irq0, 1'b0);   // single cycle pulse
      check_flag("irq1", irq1, 1'b0);
   endtask

   task automatic expect_quiet();
      repeat (IRQ_WAIT)
      begin
         @(negedge clk_llc);
         check_flag("irq0", irq0, 1'b0);
         check_flag("irq1", irq1, 1'b0);
      end
   endtask

   // back-to-back reads, data expected one cycle after each strobe
   task automatic read_back(input logic bank, input int count);
      int i;
      for (i = 0; i <= count; i++)
      begin
         @(posedge clk_llc);
         if (i < count)
         begin
            host_rd  <= 1'b1;
            host_adr <= ADR_W'(i);
         end
         else
            host_rd <= 1'b0;
         @(negedge clk_llc);
         check_flag("host_valid", host_valid, i > 0);
         if (i > 0 && known[bank][i-1])
            check_pixel($sformatf("host_data[%0d]", i - 1), host_data, model[bank][i-1]);
      end
   endtask

   //------------------------------------------------------------------------
   // watchdog
   //------------------------------------------------------------------------
   initial
   begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk_llc);
      $display("watchdog expired, run took more than %0d cycles", limit_cycles);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
   end

   //------------------------------------------------------------------------
   // main sequence
   //------------------------------------------------------------------------
   initial
   begin
      int               rec;
      int               base;
      int               n_rec;
      int               lines;
      int               pairs;
      int               kept;
      int               n_read;
      int               a;
      int               budget;
      logic             wr_bank_exp;
      logic             rd_bank;
      logic [PIX_W-1:0] colour;

      resetx     = 1'b0;
      vref       = 1'b0;
      href       = 1'b0;
      odd        = 1'b0;
      vpo        = '0;
      host_rd    = 1'b0;
      host_adr   = '0;
      lfsr_state = 16'd16168;
      $readmemh("test/frame_trace.txt", trace_mem);
      n_rec = int'(trace_mem[0]);

      // field lengths plus interrupt wait and readback per record
      budget = 100;
      for (rec = 0; rec < n_rec; rec++)
      begin
         base   = 1 + rec * REC_W;
         lines  = int'(trace_mem[base+1]);
         pairs  = int'(trace_mem[base+2]);
         budget = budget + 8 + lines * (4 * pairs + 10) + 2 * IRQ_WAIT;
         budget = budget + kept_words(lines, pairs) + MIN_READ + 4;
      end
      limit_cycles = budget;

      repeat (4) @(posedge clk_llc);
      resetx <= 1'b1;
      @(negedge clk_llc);
      check_flag("irq0", irq0, 1'b0);
      check_flag("irq1", irq1, 1'b0);
      check_flag("host_valid", host_valid, 1'b0);
      check_pixel("host_data", host_data, '0);

      wr_bank_exp = 1'b0;
      for (rec = 0; rec < n_rec; rec++)
      begin
         base   = 1 + rec * REC_W;
         lines  = int'(trace_mem[base+1]);
         pairs  = int'(trace_mem[base+2]);
         colour = trace_mem[base+6];
         kept   = kept_words(lines, pairs);
         drive_field(trace_mem[base][0], lines, pairs, trace_mem[base+3][BYTE_W-1:0],
                     trace_mem[base+4][BYTE_W-1:0], trace_mem[base+5][BYTE_W-1:0]);
         if (trace_mem[base][0])
         begin
            wait_irq(wr_bank_exp);
            for (a = 0; a < kept; a++)
            begin
               model[wr_bank_exp][a] = colour;
               known[wr_bank_exp][a] = 1'b1;
            end
            wr_bank_exp = ~wr_bank_exp;
         end
         else
            expect_quiet();                 // even field, nothing written
         rd_bank = ~wr_bank_exp;
         n_read  = kept + 1;
         if (n_read < MIN_READ)
            n_read = MIN_READ;
         if (n_read > int'(FB_WORDS))
            n_read = int'(FB_WORDS);
         read_back(rd_bank, n_read);
      end

      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: video_front_end.f
rtl/vision_pkg.sv
rtl/ycbcr_capture.sv
rtl/ycbcr_to_rgb565.sv
rtl/frame_writer.sv
rtl/frame_buffer.sv
rtl/video_front_end.sv
test/tb_clock_gen.sv
test/tb_video_front_end.sv

// File: Makefile
# Verilator lint and simulation of the video front end

VERILATOR ?= verilator
TOP       ?= tb_video_front_end
RTL_TOP   ?= video_front_end
FILELIST  ?= video_front_end.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter rtl/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --assert --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "STATUS: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/frame_trace.txt
// first word: record count, then one record per line, all hex
// odd lines pairs cb y cr expected_rgb565
6
1 5 6 80 80 80 8410
1 4 4 80 00 80 0000
0 3 3 50 60 b0 0000
1 3 3 80 ff 80 ffff
1 6 5 50 60 b0 aa40
1 2 2 c0 a0 40 461f
